/* Makefile */
# Verilator flow for the APB floating-point multiplier

TOP := fpMulTb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the log holds the pass line
run: build
	rm -f $(LOG)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall -f src.f --top-module fpMulTop

clean:
	rm -rf obj_dir $(LOG)

/* include/fpMul_macros.svh */
`ifndef FPMUL_MACROS_SVH
`define FPMUL_MACROS_SVH

//////////////////////////////////////////////////
// Single precision format
//////////////////////////////////////////////////

// Significand width with the hidden bit
`define FPMUL_SGF_WIDTH 24
// Biased exponent field
`define FPMUL_EXP_WIDTH 8
`define FPMUL_EXP_BIAS 127
// Quiet NaN for any special operand
`define FPMUL_QNAN 32'h7FC00000

//////////////////////////////////////////////////
// APB register map, byte offsets
//////////////////////////////////////////////////

`define FPMUL_ADDR_OPA 5'h00
`define FPMUL_ADDR_OPB 5'h04
`define FPMUL_ADDR_CTRL 5'h08
`define FPMUL_ADDR_STATUS 5'h0C
`define FPMUL_ADDR_RESULT 5'h10

`endif

/* source/apbBusPkg.sv */
`default_nettype none
`include "fpMul_macros.svh"

package apbBusPkg;

    // Bus data word
    typedef logic [31:0] busWord_t;
    // Byte address, five registers fit in 5 bits
    typedef logic [4:0] busAddr_t;

    // Master to slave
    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        busAddr_t paddr;
        busWord_t pwdata;
    } apbReq_t;

    // Slave to master
    typedef struct packed {
        busWord_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    // Register offsets
    typedef enum busAddr_t {
        REG_OPA    = `FPMUL_ADDR_OPA,
        REG_OPB    = `FPMUL_ADDR_OPB,
        REG_CTRL   = `FPMUL_ADDR_CTRL,
        REG_STATUS = `FPMUL_ADDR_STATUS,
        REG_RESULT = `FPMUL_ADDR_RESULT
    } regAddr_e;

endpackage

`default_nettype wire

/* source/fpFormatPkg.sv */
`default_nettype none
`include "fpMul_macros.svh"

package fpFormatPkg;

    // Significand with hidden bit
    typedef logic [`FPMUL_SGF_WIDTH-1:0] sgf_t;
    // Full significand product
    typedef logic [2*`FPMUL_SGF_WIDTH-1:0] sgfProd_t;
    // Biased exponent field
    typedef logic [`FPMUL_EXP_WIDTH-1:0] exp_t;
    // Exponent arithmetic, two guard bits, two's complement
    typedef logic signed [`FPMUL_EXP_WIDTH+1:0] expCalc_t;
    // Stored fraction without hidden bit
    typedef logic [`FPMUL_SGF_WIDTH-2:0] frac_t;

    // IEEE single layout, sign on top
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        frac_t frac;
    } fpWord_t;

    // Operand pair into the datapath
    typedef struct packed {
        fpWord_t a;
        fpWord_t b;
        logic    valid;
    } fpOperands_t;

    // Product out of the datapath
    typedef struct packed {
        fpWord_t word;
        logic    valid;
    } fpResult_t;

endpackage

`default_nettype wire

/* source/fpMulApbRegs.sv */
`default_nettype none

module fpMulApbRegs (
    input  wire logic                     clk_i,
    input  wire logic                     arstN_i,
    input  wire apbBusPkg::apbReq_t       apbReq_i,
    output apbBusPkg::apbRsp_t            apbRsp_o,
    output fpFormatPkg::fpOperands_t      operands_o,
    input  wire fpFormatPkg::fpResult_t   result_i
);

    import apbBusPkg::*;
    import fpFormatPkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } ctrlState_e;

    ctrlState_e state;
    busWord_t   opAReg;
    busWord_t   opBReg;
    busWord_t   resultReg;
    busWord_t   readData;
    regAddr_e   regAddr;
    logic       done;
    logic       busy;
    logic       startPulse;
    logic       access;
    logic       wrAccess;
    logic       rdAccess;
    logic       addrHit;
    logic       wrRejected;
    logic       startReq;
    logic       startAccepted;

    //////////////////////////////////////////////////
    // Access decode
    //////////////////////////////////////////////////

    // Access phase, pready is tied high
    assign access = apbReq_i.psel && apbReq_i.penable;
    assign wrAccess = access && apbReq_i.pwrite;
    assign rdAccess = access && !apbReq_i.pwrite;
    assign regAddr = regAddr_e'(apbReq_i.paddr);
    assign busy = (state == BUSY);

    // Read mux and address check
    always_comb begin
        addrHit = 1'b1;
        readData = '0;
        case (regAddr)
            REG_OPA:    readData = opAReg;
            REG_OPB:    readData = opBReg;
            // Start bit is self clearing
            REG_CTRL:   readData = '0;
            REG_STATUS: readData = busWord_t'({done, busy});
            REG_RESULT: readData = resultReg;
            default:    addrHit = 1'b0;
        endcase
    end

    // Read only registers
    assign wrRejected = wrAccess && (regAddr == REG_STATUS || regAddr == REG_RESULT);
    assign startReq = wrAccess && (regAddr == REG_CTRL) && apbReq_i.pwdata[0];
    // Start while busy is dropped
    assign startAccepted = startReq && !busy;

    assign apbRsp_o = '{
        prdata:  rdAccess ? readData : '0,
        pready:  1'b1,
        pslverr: (access && !addrHit) || wrRejected || (startReq && busy)
    };

    //////////////////////////////////////////////////
    // Operand registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            opAReg <= '0;
            opBReg <= '0;
        end else if (wrAccess) begin
            if (regAddr == REG_OPA) begin
                opAReg <= apbReq_i.pwdata;
            end
            if (regAddr == REG_OPB) begin
                opBReg <= apbReq_i.pwdata;
            end
        end
    end

    // Valid pulse one cycle after the CTRL write
    assign operands_o = '{a: fpWord_t'(opAReg), b: fpWord_t'(opBReg), valid: startPulse};

    //////////////////////////////////////////////////
    // Busy and done control
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= IDLE;
            startPulse <= 1'b0;
            done <= 1'b0;
            resultReg <= '0;
        end else begin
            startPulse <= startAccepted;
            case (state)
                IDLE: begin
                    if (startAccepted) begin
                        state <= BUSY;
                        done <= 1'b0;
                    end
                end
                BUSY: begin
                    // Capture product and flag done
                    if (result_i.valid) begin
                        state <= IDLE;
                        done <= 1'b1;
                        resultReg <= busWord_t'(result_i.word);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/fpMulDatapath.sv */
`default_nettype none
`include "fpMul_macros.svh"

module fpMulDatapath (
    input  wire logic                     clk_i,
    input  wire logic                     arstN_i,
    input  wire fpFormatPkg::fpOperands_t operands_i,
    output fpFormatPkg::fpResult_t        result_o
);

    import fpFormatPkg::*;

    localparam int SgfW = `FPMUL_SGF_WIDTH;
    localparam expCalc_t ExpBias = expCalc_t'(`FPMUL_EXP_BIAS);
    // All ones exponent, infinity threshold
    localparam expCalc_t ExpMax = expCalc_t'((1 << `FPMUL_EXP_WIDTH) - 1);

    // Side values travelling with the significands
    typedef struct packed {
        logic     sign;
        logic     zero;
        logic     special;
        expCalc_t exp;
    } sideInfo_t;

    // Stage valids, bit 0 is the operand register
    logic [3:0] validPipe;
    fpWord_t    opA;
    fpWord_t    opB;
    sgf_t       sgfA;
    sgf_t       sgfB;
    sideInfo_t  side1;
    sideInfo_t  side2;
    sideInfo_t  side3;
    sgfProd_t   product3;
    logic       normShift;
    expCalc_t   expNorm;
    frac_t      fracNorm;
    fpWord_t    word3;
    fpWord_t    resultWord;

    //////////////////////////////////////////////////
    // Stage 1, operand register and unpack
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[2:0], operands_i.valid};
        end
    end

    always_ff @(posedge clk_i) begin
        if (operands_i.valid) begin
            opA <= operands_i.a;
            opB <= operands_i.b;
        end
    end

    // Hidden bit only for normal operands
    assign sgfA = {opA.exp != '0, opA.frac};
    assign sgfB = {opB.exp != '0, opB.frac};

    // Zero exponent covers zero and subnormal
    assign side1.sign = opA.sign ^ opB.sign;
    assign side1.zero = (opA.exp == '0) || (opB.exp == '0);
    assign side1.special = (opA.exp == '1) || (opB.exp == '1);
    assign side1.exp = expCalc_t'(opA.exp) + expCalc_t'(opB.exp) - ExpBias;

    // Side values follow stages 2 and 3
    always_ff @(posedge clk_i) begin
        if (validPipe[0]) begin
            side2 <= side1;
        end
        if (validPipe[1]) begin
            side3 <= side2;
        end
    end

    //////////////////////////////////////////////////
    // Stages 2 and 3, significand product
    //////////////////////////////////////////////////

    sgfMultiplication #(.SW(SgfW)) sgfMultiplication_inst (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .loadResult_i(validPipe[1]),
        .dataA_i     (sgfA),
        .dataB_i     (sgfB),
        .sgfResult_o (product3)
    );

    // Product in [1,4), at most one shift
    assign normShift = product3[2*SgfW-1];
    assign expNorm = normShift ? side3.exp + expCalc_t'(1) : side3.exp;
    // Truncate, round toward zero
    assign fracNorm = normShift ? product3[2*SgfW-2 -: SgfW-1]
                                : product3[2*SgfW-3 -: SgfW-1];

    always_comb begin
        word3.sign = side3.sign;
        word3.exp = expNorm[`FPMUL_EXP_WIDTH-1:0];
        word3.frac = fracNorm;
        if (side3.special) begin
            word3 = fpWord_t'(`FPMUL_QNAN);
        end else if (side3.zero || expNorm < expCalc_t'(1)) begin
            // Flush to signed zero
            word3.exp = '0;
            word3.frac = '0;
        end else if (expNorm >= ExpMax) begin
            // Saturate to signed infinity
            word3.exp = '1;
            word3.frac = '0;
        end
    end

    //////////////////////////////////////////////////
    // Stage 4, pack register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (validPipe[2]) begin
            resultWord <= word3;
        end
    end

    assign result_o = '{word: resultWord, valid: validPipe[3]};

endmodule

`default_nettype wire

/* source/fpMulTop.sv */
`default_nettype none

module fpMulTop (
    input  wire logic               clk_i,
    input  wire logic               arstN_i,
    input  wire apbBusPkg::apbReq_t apbReq_i,
    output apbBusPkg::apbRsp_t      apbRsp_o
);

    import fpFormatPkg::*;

    // Operand pair with start pulse
    fpOperands_t operands;
    // Packed product with done pulse
    fpResult_t   result;

    //////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////

    // APB decode, registers and control
    fpMulApbRegs fpMulApbRegs_inst (
        .clk_i     (clk_i),
        .arstN_i   (arstN_i),
        .apbReq_i  (apbReq_i),
        .apbRsp_o  (apbRsp_o),
        .operands_o(operands),
        .result_i  (result)
    );

    //////////////////////////////////////////////////
    // Multiplier datapath
    //////////////////////////////////////////////////

    // Four cycles from operands to result
    fpMulDatapath fpMulDatapath_inst (
        .clk_i     (clk_i),
        .arstN_i   (arstN_i),
        .operands_i(operands),
        .result_o  (result)
    );

endmodule

`default_nettype wire

/* source/sgfMultiplication.sv */
`default_nettype none
`include "fpMul_macros.svh"

module sgfMultiplication #(
    parameter int SW = `FPMUL_SGF_WIDTH
) (
    input  wire logic            clk_i,
    input  wire logic            arstN_i,
    input  wire logic            loadResult_i,
    input  wire logic [SW-1:0]   dataA_i,
    input  wire logic [SW-1:0]   dataB_i,
    output logic      [2*SW-1:0] sgfResult_o
);

    // High half width
    localparam int HW = SW / 2;
    // Low half, one bit wider for odd SW
    localparam int LW = SW - HW;
    // Half sums carry one extra bit
    localparam int MW = LW + 1;

    // Half sums for the middle term
    logic [MW-1:0]   sumA;
    logic [MW-1:0]   sumB;
    // Registered sub-products
    logic [2*HW-1:0] leftProd;
    logic [2*LW-1:0] rightProd;
    logic [2*MW-1:0] middleProd;
    // Cross terms after both subtractions
    logic [2*MW-1:0] middleLess;
    logic [2*MW-1:0] middleTerm;
    // Cross terms aligned to the product
    logic [2*SW-1:0] middleShift;
    logic [2*SW-1:0] resultSum;

    //////////////////////////////////////////////////
    // Half sums and padding per parity
    //////////////////////////////////////////////////

    generate
        if (SW % 2 == 0) begin : genEven
            // Halves of equal width
            assign sumA = {1'b0, dataA_i[SW-1:LW]} + {1'b0, dataA_i[LW-1:0]};
            assign sumB = {1'b0, dataB_i[SW-1:LW]} + {1'b0, dataB_i[LW-1:0]};
            assign middleLess = middleProd - {2'b00, leftProd};
            assign middleShift = {{(HW-2){1'b0}}, middleTerm, {LW{1'b0}}};
        end else begin : genOdd
            // High half is one bit narrower
            assign sumA = {2'b00, dataA_i[SW-1:LW]} + {1'b0, dataA_i[LW-1:0]};
            assign sumB = {2'b00, dataB_i[SW-1:LW]} + {1'b0, dataB_i[LW-1:0]};
            assign middleLess = middleProd - {4'b0000, leftProd};
            assign middleShift = {{(HW-3){1'b0}}, middleTerm, {LW{1'b0}}};
        end
    endgenerate

    // Cross terms ha*lb + la*hb
    assign middleTerm = middleLess - {2'b00, rightProd};

    // Left and right products never overlap
    assign resultSum = {leftProd, rightProd} + middleShift;

    //////////////////////////////////////////////////
    // Sub-products, cycle 1
    //////////////////////////////////////////////////

    sgfPartialMult #(.W(HW)) left (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .dataA_i  (dataA_i[SW-1:LW]),
        .dataB_i  (dataB_i[SW-1:LW]),
        .product_o(leftProd)
    );

    sgfPartialMult #(.W(LW)) right (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .dataA_i  (dataA_i[LW-1:0]),
        .dataB_i  (dataB_i[LW-1:0]),
        .product_o(rightProd)
    );

    sgfPartialMult #(.W(MW)) middle (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .dataA_i  (sumA),
        .dataB_i  (sumB),
        .product_o(middleProd)
    );

    // Result register, cycle 2, holds without load
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            sgfResult_o <= '0;
        end else if (loadResult_i) begin
            sgfResult_o <= resultSum;
        end
    end

endmodule

`default_nettype wire

/* source/sgfPartialMult.sv */
`default_nettype none

module sgfPartialMult #(
    parameter int W = 12
) (
    input  wire logic           clk_i,
    input  wire logic           arstN_i,
    input  wire logic [W-1:0]   dataA_i,
    input  wire logic [W-1:0]   dataB_i,
    output logic      [2*W-1:0] product_o
);

    // Full width product, operands widened first
    logic [2*W-1:0] productNext;

    assign productNext = (2*W)'(dataA_i) * (2*W)'(dataB_i);

    //////////////////////////////////////////////////
    // One register stage
    //////////////////////////////////////////////////

    // Same depth for all three Karatsuba terms
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            product_o <= '0;
        end else begin
            product_o <= productNext;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/fpFormatPkg.sv
source/apbBusPkg.sv
source/sgfPartialMult.sv
source/sgfMultiplication.sv
source/fpMulDatapath.sv
source/fpMulApbRegs.sv
source/fpMulTop.sv
testbench/fpMulTb.sv

/* testbench/fpMulTb.sv */
`default_nettype none
`include "fpMul_macros.svh"

module fpMulTb;

    timeunit 1ns;
    timeprecision 100ps;

    import fpFormatPkg::*;
    import apbBusPkg::*;

    localparam int HalfPeriod = 50;
    // Bounds for every wait loop
    localparam int MaxReadyWait = 4;
    localparam int MaxPolls = 20;
    localparam int RandomPairs = 200;

    logic        clk;
    logic        arstN;
    apbReq_t     apbReq;
    apbRsp_t     apbRsp;
    logic [31:0] lfsrState;

    fpMulTop fpMulTop_inst (
        .clk_i   (clk),
        .arstN_i (arstN),
        .apbReq_i(apbReq),
        .apbRsp_o(apbRsp)
    );

    // 100 ns period
    always begin
        #HalfPeriod clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure and compare tasks
    //////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWord(input string name, input fpWord_t expected, input fpWord_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkStatus(input string name, input busWord_t expected,
                               input busWord_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkResp(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH %s pslverr expected %b actual %b",
                               name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model and random operands
    //////////////////////////////////////////////////

    // Truncating multiply with flush and saturation
    function automatic fpWord_t refFpMul(input fpWord_t a, input fpWord_t b);
        logic [47:0] prod;
        int          expSum;
        fpWord_t     r;
        r.sign = a.sign ^ b.sign;
        r.exp = '0;
        r.frac = '0;
        // NaN wins over everything, zero over overflow
        if (a.exp == 8'hFF || b.exp == 8'hFF) begin
            return fpWord_t'(32'h7FC00000);
        end
        if (a.exp == 8'h00 || b.exp == 8'h00) begin
            return r;
        end
        prod = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
        expSum = int'(a.exp) + int'(b.exp) - 127;
        if (prod[47]) begin
            expSum = expSum + 1;
            r.frac = prod[46:24];
        end else begin
            r.frac = prod[45:23];
        end
        if (expSum < 1) begin
            r.frac = '0;
        end else if (expSum >= 255) begin
            r.exp = 8'hFF;
            r.frac = '0;
        end else begin
            r.exp = 8'(expSum);
        end
        return r;
    endfunction

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    function automatic fpWord_t randomOperand();
        fpWord_t     word;
        logic [31:0] bits;
        logic        wide;
        bits = takeBits(1);
        word.sign = bits[0];
        bits = takeBits(23);
        word.frac = bits[22:0];
        bits = takeBits(2);
        wide = &bits[1:0];
        bits = takeBits(8);
        // Mostly near the bias, a quarter over the full field
        word.exp = wide ? bits[7:0] : 8'd96 + {2'b00, bits[5:0]};
        return word;
    endfunction

    //////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////

    // Called on a falling edge, returns on a falling edge
    task automatic apbTransfer(input logic write, input busAddr_t addr, input busWord_t wdata,
                               output busWord_t rdata, output logic err);
        int waitCycles;
        waitCycles = 0;
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = write;
        apbReq.paddr = addr;
        apbReq.pwdata = write ? wdata : '0;
        @(negedge clk);
        apbReq.penable = 1'b1;
        // Sample mid low phase
        #(HalfPeriod / 2);
        while (!apbRsp.pready) begin
            if (waitCycles >= MaxReadyWait) begin
                abortRun("APB slave never raised pready");
            end
            waitCycles++;
            @(negedge clk);
            #(HalfPeriod / 2);
        end
        rdata = apbRsp.prdata;
        err = apbRsp.pslverr;
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic apbWrite(input busAddr_t addr, input busWord_t data, output logic err);
        busWord_t unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input busAddr_t addr, output busWord_t data, output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    //////////////////////////////////////////////////
    // Test steps
    //////////////////////////////////////////////////

    // Poll STATUS until done
    task automatic waitDone(input string name);
        busWord_t status;
        logic     err;
        int       polls;
        polls = 0;
        status = '0;
        while (!status[1]) begin
            if (polls >= MaxPolls) begin
                abortRun($sformatf("%s: done never rose in STATUS", name));
            end
            polls++;
            apbRead(`FPMUL_ADDR_STATUS, status, err);
            checkResp({name, " status poll"}, 1'b0, err);
            // Busy until done is set
            if (!status[1]) begin
                checkStatus({name, " busy status"}, 32'h1, status);
            end
        end
        // Idle with done set
        checkStatus({name, " status"}, 32'h2, status);
    endtask

    task automatic readResult(input string name, input fpWord_t expected);
        busWord_t data;
        logic     err;
        apbRead(`FPMUL_ADDR_RESULT, data, err);
        checkResp({name, " result read"}, 1'b0, err);
        checkWord(name, expected, fpWord_t'(data));
    endtask

    task automatic runProduct(input string name, input fpWord_t a, input fpWord_t b);
        logic err;
        apbWrite(`FPMUL_ADDR_OPA, busWord_t'(a), err);
        checkResp({name, " opa write"}, 1'b0, err);
        apbWrite(`FPMUL_ADDR_OPB, busWord_t'(b), err);
        checkResp({name, " opb write"}, 1'b0, err);
        apbWrite(`FPMUL_ADDR_CTRL, 32'h1, err);
        checkResp({name, " start"}, 1'b0, err);
        waitDone(name);
        readResult(name, refFpMul(a, b));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        busWord_t data;
        logic     err;
        clk = 1'b0;
        arstN = 1'b0;
        apbReq = '0;
        lfsrState = 32'h21b2_c4af;
        repeat (3) @(negedge clk);
        arstN = 1'b1;

        // Reset values
        apbRead(`FPMUL_ADDR_STATUS, data, err);
        checkResp("reset status", 1'b0, err);
        checkStatus("reset status", 32'h0, data);
        readResult("reset result", fpWord_t'(32'h0));

        // Directed products, some needing the normalize shift
        runProduct("1.5 x 2.0", 32'h3FC0_0000, 32'h4000_0000);
        runProduct("-3 x 0.25", 32'hC040_0000, 32'h3E80_0000);
        runProduct("1.5 x 1.5", 32'h3FC0_0000, 32'h3FC0_0000);
        runProduct("1.75 x 1.75", 32'h3FE0_0000, 32'h3FE0_0000);
        runProduct("max sgf squared", 32'h3FFF_FFFF, 32'h3FFF_FFFF);
        runProduct("1.1 x 3.3", 32'h3F8C_CCCD, 32'h4053_3333);
        runProduct("max normal x 1", 32'h7F7F_FFFF, 32'h3F80_0000);
        runProduct("min normal x 1", 32'h0080_0000, 32'h3F80_0000);

        // Special cases
        runProduct("zero x 5", 32'h0000_0000, 32'h40A0_0000);
        runProduct("neg zero x 2", 32'h8000_0000, 32'h4000_0000);
        runProduct("subnormal x 2", 32'h0040_0000, 32'h4000_0000);
        runProduct("subnormal x -2", 32'h0000_0001, 32'hC000_0000);
        runProduct("overflow", 32'h7F00_0000, 32'h7F00_0000);
        runProduct("neg overflow", 32'hFF00_0000, 32'h7F00_0000);
        runProduct("overflow by shift", 32'h7F7F_FFFF, 32'h3FC0_0000);
        runProduct("underflow", 32'h0080_0000, 32'h0080_0000);
        runProduct("small sum", 32'h0D00_0000, 32'h8D00_0000);
        runProduct("inf x 1", 32'h7F80_0000, 32'h3F80_0000);
        runProduct("nan x zero", 32'h7FC1_2345, 32'h0000_0000);

        // Random operand pairs
        for (int i = 0; i < RandomPairs; i++) begin
            fpWord_t a;
            fpWord_t b;
            a = randomOperand();
            b = randomOperand();
            runProduct($sformatf("random %0d", i), a, b);
        end

        // Bus errors
        apbRead(5'h14, data, err);
        checkResp("unmapped read 0x14", 1'b1, err);
        apbRead(5'h1C, data, err);
        checkResp("unmapped read 0x1C", 1'b1, err);
        apbWrite(`FPMUL_ADDR_RESULT, 32'hDEAD_BEEF, err);
        checkResp("result write", 1'b1, err);
        apbWrite(`FPMUL_ADDR_STATUS, 32'h3, err);
        checkResp("status write", 1'b1, err);

        // Second start while busy is refused
        apbWrite(`FPMUL_ADDR_OPA, 32'h4040_0000, err);
        checkResp("busy opa write", 1'b0, err);
        apbWrite(`FPMUL_ADDR_OPB, 32'hC0A0_0000, err);
        checkResp("busy opb write", 1'b0, err);
        apbWrite(`FPMUL_ADDR_CTRL, 32'h1, err);
        checkResp("first start", 1'b0, err);
        apbWrite(`FPMUL_ADDR_CTRL, 32'h1, err);
        checkResp("start while busy", 1'b1, err);
        // Operands already latched by the datapath
        apbWrite(`FPMUL_ADDR_OPA, 32'h3F80_0000, err);
        checkResp("late opa write", 1'b0, err);
        waitDone("busy start");
        readResult("busy start", refFpMul(32'h4040_0000, 32'hC0A0_0000));

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
